//--- hdl/osd_pkg.sv
/*
 * Shared definitions for the on-screen display.
 * Vector types for pixel counters, colours, BCD words, character codes
 * and text positions, plus the character cell geometry.
 */
`default_nettype none

package osd_pkg;

        // Character cell size in pixels
        localparam int cell_w = 8;
        localparam int cell_h = 16;

        localparam int max_words = 16;  // Largest word count the index can address

        typedef logic [11:0] coord_t;   // hcount or vcount
        typedef logic [11:0] rgb_t;     // 4 bits each of red, green, blue

        // Four BCD digits, most significant digit in the top nibble
        typedef logic [15:0] bcd_word_t;

        typedef logic [6:0] ascii_t;

        // Text line in the upper four bits, column in the lower two
        typedef logic [5:0] text_pos_t;

        typedef logic [$clog2(cell_h)-1:0] cell_row_t;

        // Column 0 of the cell sits in the most significant bit
        typedef logic [cell_w-1:0] glyph_row_t;

        typedef logic [$clog2(max_words)-1:0] word_idx_t;

endpackage

`default_nettype wire

//--- hdl/video_if.sv
/*
 * One pixel of the video stream.
 * Counters, sync and blanking levels and the colour, with a source side
 * that drives them and a sink side that reads them.
 */
`default_nettype none

interface video_if;
        import osd_pkg::*;

        coord_t vcount;
        coord_t hcount;
        logic   vsync;
        logic   hsync;
        logic   vblnk;
        logic   hblnk;
        rgb_t   rgb;

        modport src (
                output vcount, hcount, vsync, hsync, vblnk, hblnk, rgb
        );

        modport dst (
                input vcount, hcount, vsync, hsync, vblnk, hblnk, rgb
        );

endinterface

`default_nettype wire

//--- hdl/snapshot_fsm.sv
/*
 * Capture control for the text buffer.
 * On each rising edge of vertical blanking it walks the word counter
 * once through all input words and writes them, then waits for the
 * end of blanking.
 */
`default_nettype none

module snapshot_fsm (
        input  logic pclk,
        input  logic rst,
        input  logic vblnk,
        input  logic last,
        output logic clear,
        output logic step,
        output logic wr_en
);
        typedef enum logic [1:0] {
                idle,
                load,
                hold
        } state_t;

        state_t state;
        state_t state_nxt;
        logic   vblnk_prev;
        logic   vblnk_rise;

        assign vblnk_rise = vblnk && !vblnk_prev;

        always_ff @(posedge pclk) begin
                if (rst) begin
                        state      <= idle;
                        vblnk_prev <= 1'b0;
                end else begin
                        state      <= state_nxt;
                        vblnk_prev <= vblnk;
                end
        end

        always_comb begin
                state_nxt = state;
                case (state)
                        idle: if (vblnk_rise) state_nxt = load;
                        load: if (last) state_nxt = hold;   // Last word is written this cycle
                        hold: if (!vblnk) state_nxt = idle;
                        default: state_nxt = idle;
                endcase
        end

        // One word per cycle while loading
        assign step  = (state == load);
        assign wr_en = (state == load);

        assign clear = (state == hold);   // Counter overran on the last step

endmodule

`default_nettype wire

//--- hdl/word_counter.sv
/*
 * Word index counter for the frame capture.
 * Steps through the input words and flags the last one.
 */
`default_nettype none

module word_counter #(
        parameter int num_words = 13
) (
        input  logic                pclk,
        input  logic                rst,
        input  logic                clear,
        input  logic                step,
        output osd_pkg::word_idx_t  index,
        output logic                last
);
        import osd_pkg::*;

        localparam word_idx_t last_idx = word_idx_t'(num_words - 1);

        always_ff @(posedge pclk) begin
                if (rst || clear) begin
                        index <= '0;
                end else if (step) begin
                        index <= index + 1'b1;
                end
        end

        assign last = (index == last_idx);

endmodule

`default_nettype wire

//--- hdl/text_buffer.sv
/*
 * Text buffer of the display, four characters per input word.
 * BCD digits become ASCII on write, other nibble values become spaces.
 * Character codes are read by text position with one cycle of latency.
 */
`default_nettype none

module text_buffer #(
        parameter int num_words = 13
) (
        input  logic                                pclk,
        input  logic                                rst,
        input  logic                                wr_en,
        input  osd_pkg::word_idx_t                  index,
        input  osd_pkg::bcd_word_t [num_words-1:0]  bcd_words,
        input  osd_pkg::text_pos_t                  text_pos,
        output osd_pkg::ascii_t                     char_code
);
        import osd_pkg::*;

        localparam int     num_cols   = 4;
        localparam ascii_t space_char = 7'h20;

        ascii_t    text_mem [num_words][num_cols];
        bcd_word_t wr_word;
        word_idx_t rd_line;
        logic [1:0] rd_col;

        function automatic ascii_t to_ascii(input logic [3:0] nibble);
                if (nibble <= 4'd9)
                        return {3'b011, nibble};   // '0' is 7'h30
                return space_char;
        endfunction

        assign wr_word = bcd_words[index];
        assign rd_line = text_pos[5:2];
        assign rd_col  = text_pos[1:0];

        always_ff @(posedge pclk) begin
                if (rst) begin
                        for (int n = 0; n < num_words; n++) begin
                                for (int k = 0; k < num_cols; k++) begin
                                        text_mem[n][k] <= space_char;
                                end
                        end
                end else if (wr_en) begin
                        // Column 0 holds the most significant digit
                        for (int k = 0; k < num_cols; k++) begin
                                text_mem[index][k] <= to_ascii(wr_word[(num_cols-1-k)*4 +: 4]);
                        end
                end
        end

        always_ff @(posedge pclk) begin
                if (int'(rd_line) < num_words)
                        char_code <= text_mem[rd_line][rd_col];
                else
                        char_code <= space_char;
        end

endmodule

`default_nettype wire

//--- hdl/glyph_gen.sv
/*
 * Seven-segment glyph generator for the digits '0' to '9'.
 * Gives one registered 8-pixel row of a character cell, other codes
 * give an empty row.
 */
`default_nettype none

module glyph_gen (
        input  logic                  pclk,
        input  osd_pkg::ascii_t       char_code,
        input  osd_pkg::cell_row_t    cell_row,
        output osd_pkg::glyph_row_t   glyph_row
);
        import osd_pkg::*;

        localparam int mid = cell_h / 2;   // First row of the lower half

        logic [6:0] segs;   // {a, b, c, d, e, f, g}
        glyph_row_t row_c;

        function automatic logic in_rows(input cell_row_t r, input int lo, input int hi);
                return (int'(r) >= lo) && (int'(r) <= hi);
        endfunction

        function automatic glyph_row_t col_span(input int lo, input int hi);
                glyph_row_t mask;
                mask = '0;
                for (int c = 0; c < cell_w; c++) begin
                        if (c >= lo && c <= hi)
                                mask[cell_w-1-c] = 1'b1;
                end
                return mask;
        endfunction

        always_comb begin
                case (char_code)
                        7'h30: segs = 7'b1111110;
                        7'h31: segs = 7'b0110000;
                        7'h32: segs = 7'b1101101;
                        7'h33: segs = 7'b1111001;
                        7'h34: segs = 7'b0110011;
                        7'h35: segs = 7'b1011011;
                        7'h36: segs = 7'b1011111;
                        7'h37: segs = 7'b1110000;
                        7'h38: segs = 7'b1111111;
                        7'h39: segs = 7'b1111011;
                        default: segs = 7'b0000000;
                endcase
        end

        always_comb begin
                row_c = '0;
                if (segs[6] && in_rows(cell_row, 1, 2))
                        row_c |= col_span(1, cell_w - 2);                   // a
                if (segs[5] && in_rows(cell_row, 2, mid - 1))
                        row_c |= col_span(cell_w - 2, cell_w - 1);          // b
                if (segs[4] && in_rows(cell_row, mid, cell_h - 3))
                        row_c |= col_span(cell_w - 2, cell_w - 1);          // c
                if (segs[3] && in_rows(cell_row, cell_h - 3, cell_h - 2))
                        row_c |= col_span(1, cell_w - 2);                   // d
                if (segs[2] && in_rows(cell_row, mid, cell_h - 3))
                        row_c |= col_span(0, 1);                            // e
                if (segs[1] && in_rows(cell_row, 2, mid - 1))
                        row_c |= col_span(0, 1);                            // f
                if (segs[0] && in_rows(cell_row, mid - 1, mid))
                        row_c |= col_span(1, cell_w - 2);                   // g
        end

        always_ff @(posedge pclk) begin
                glyph_row <= row_c;
        end

endmodule

`default_nettype wire

//--- hdl/osd_draw.sv
/*
 * Text box drawer.
 * Delays the video stream by four cycles, maps each pixel to a text
 * position and cell row for the lookup, and paints lit glyph pixels.
 */
`default_nettype none

module osd_draw #(
        parameter osd_pkg::coord_t xpos      = 16,
        parameter osd_pkg::coord_t ypos      = 8,
        parameter int              num_words = 13,
        parameter osd_pkg::rgb_t   text_rgb  = 12'hfff
) (
        input  logic                 pclk,
        input  logic                 rst,
        video_if.dst                 vid_in,
        video_if.src                 vid_out,
        output osd_pkg::text_pos_t   text_pos,
        output osd_pkg::cell_row_t   cell_row,
        input  osd_pkg::glyph_row_t  glyph_row
);
        import osd_pkg::*;

        localparam int     num_cols = 4;
        localparam int     col_bits = $clog2(cell_w);
        localparam int     row_bits = $clog2(cell_h);
        localparam int     line_w   = $bits(text_pos_t) - 2;
        localparam coord_t x_end    = coord_t'(xpos + num_cols * cell_w);
        localparam coord_t y_end    = coord_t'(ypos + num_words * cell_h);

        coord_t dx;
        coord_t dy;
        logic   in_box_c;

        // Stages 1 to 3 of the delay line
        coord_t     vcount_d [1:3];
        coord_t     hcount_d [1:3];
        rgb_t       rgb_d    [1:3];
        logic [col_bits-1:0] pix_col_d [1:3];
        logic [1:3] vsync_d, hsync_d, vblnk_d, hblnk_d, in_box_d;
        cell_row_t  cell_row_s1;

        assign dx = vid_in.hcount - xpos;
        assign dy = vid_in.vcount - ypos;

        assign in_box_c = (vid_in.hcount >= xpos) && (vid_in.hcount < x_end) &&
                          (vid_in.vcount >= ypos) && (vid_in.vcount < y_end);

        always_ff @(posedge pclk) begin
                if (rst) begin
                        {vsync_d, hsync_d, vblnk_d, hblnk_d, in_box_d} <= '0;
                        vid_out.vsync <= 1'b0;
                        vid_out.hsync <= 1'b0;
                        vid_out.vblnk <= 1'b0;
                        vid_out.hblnk <= 1'b0;
                end else begin
                        vsync_d  <= {vid_in.vsync, vsync_d[1:2]};
                        hsync_d  <= {vid_in.hsync, hsync_d[1:2]};
                        vblnk_d  <= {vid_in.vblnk, vblnk_d[1:2]};
                        hblnk_d  <= {vid_in.hblnk, hblnk_d[1:2]};
                        in_box_d <= {in_box_c, in_box_d[1:2]};
                        vid_out.vsync <= vsync_d[3];
                        vid_out.hsync <= hsync_d[3];
                        vid_out.vblnk <= vblnk_d[3];
                        vid_out.hblnk <= hblnk_d[3];
                end
        end

        always_ff @(posedge pclk) begin
                text_pos    <= {dy[row_bits +: line_w], dx[col_bits +: 2]};
                cell_row_s1 <= dy[row_bits-1:0];
                cell_row    <= cell_row_s1;   // Meets char_code at the glyph generator

                vcount_d[1]  <= vid_in.vcount;
                hcount_d[1]  <= vid_in.hcount;
                rgb_d[1]     <= vid_in.rgb;
                pix_col_d[1] <= dx[col_bits-1:0];
                for (int s = 2; s <= 3; s++) begin
                        vcount_d[s]  <= vcount_d[s-1];
                        hcount_d[s]  <= hcount_d[s-1];
                        rgb_d[s]     <= rgb_d[s-1];
                        pix_col_d[s] <= pix_col_d[s-1];
                end

                vid_out.vcount <= vcount_d[3];
                vid_out.hcount <= hcount_d[3];
                if (in_box_d[3] && glyph_row[(cell_w - 1) - int'(pix_col_d[3])])
                        vid_out.rgb <= text_rgb;
                else
                        vid_out.rgb <= rgb_d[3];   // Unlit pixels keep the picture
        end

endmodule

`default_nettype wire

//--- hdl/osd_top.sv
/*
 * On-screen display top level.
 * Joins the video ports, the once-per-frame capture control, the text
 * buffer, the digit glyph generator and the drawer.
 */
`default_nettype none

module osd_top #(
        parameter osd_pkg::coord_t xpos      = 16,
        parameter osd_pkg::coord_t ypos      = 8,
        parameter int              num_words = 13,
        parameter osd_pkg::rgb_t   text_rgb  = 12'hfff
) (
        input  logic                                pclk,
        input  logic                                rst,
        input  osd_pkg::coord_t                     vcount_in,
        input  osd_pkg::coord_t                     hcount_in,
        input  logic                                vsync_in,
        input  logic                                hsync_in,
        input  logic                                vblnk_in,
        input  logic                                hblnk_in,
        input  osd_pkg::rgb_t                       rgb_in,
        input  osd_pkg::bcd_word_t [num_words-1:0]  bcd_words,
        output logic                                vsync_out,
        output logic                                hsync_out,
        output osd_pkg::rgb_t                       rgb_out
);
        import osd_pkg::*;

        logic       clear;
        logic       step;
        logic       wr_en;
        logic       last;
        word_idx_t  index;
        text_pos_t  text_pos;
        cell_row_t  cell_row;
        ascii_t     char_code;
        glyph_row_t glyph_row;

        video_if vid_in ();
        video_if vid_out ();

        assign vid_in.vcount = vcount_in;
        assign vid_in.hcount = hcount_in;
        assign vid_in.vsync  = vsync_in;
        assign vid_in.hsync  = hsync_in;
        assign vid_in.vblnk  = vblnk_in;
        assign vid_in.hblnk  = hblnk_in;
        assign vid_in.rgb    = rgb_in;

        assign vsync_out = vid_out.vsync;
        assign hsync_out = vid_out.hsync;
        assign rgb_out   = vid_out.rgb;

        snapshot_fsm i_snapshot_fsm (
                .pclk  (pclk),
                .rst   (rst),
                .vblnk (vblnk_in),
                .last  (last),
                .clear (clear),
                .step  (step),
                .wr_en (wr_en)
        );

        word_counter #(
                .num_words (num_words)
        ) i_word_counter (
                .pclk  (pclk),
                .rst   (rst),
                .clear (clear),
                .step  (step),
                .index (index),
                .last  (last)
        );

        text_buffer #(
                .num_words (num_words)
        ) i_text_buffer (
                .pclk      (pclk),
                .rst       (rst),
                .wr_en     (wr_en),
                .index     (index),
                .bcd_words (bcd_words),
                .text_pos  (text_pos),
                .char_code (char_code)
        );

        glyph_gen i_glyph_gen (
                .pclk      (pclk),
                .char_code (char_code),
                .cell_row  (cell_row),
                .glyph_row (glyph_row)
        );

        osd_draw #(
                .xpos      (xpos),
                .ypos      (ypos),
                .num_words (num_words),
                .text_rgb  (text_rgb)
        ) i_osd_draw (
                .pclk      (pclk),
                .rst       (rst),
                .vid_in    (vid_in.dst),
                .vid_out   (vid_out.src),
                .text_pos  (text_pos),
                .cell_row  (cell_row),
                .glyph_row (glyph_row)
        );

endmodule

`default_nettype wire

//--- sim/osd_tb.sv
/*
 * Testbench for the on-screen display.
 * Frame generator driven from the vector file, a reference pixel model
 * of the seven-segment text box, compare tasks and a cycle timeout.
 */
`default_nettype none

module osd_tb;
        import osd_pkg::*;

        localparam int num_words    = 13;
        localparam int xpos         = 16;
        localparam int ypos         = 8;
        localparam rgb_t text_rgb   = 12'h0f0;
        localparam int h_total      = 64;
        localparam int v_total      = 232;
        localparam int v_blank      = 224;   // First line of vertical blanking
        localparam int h_blank      = 48;
        localparam int frame_len    = h_total * v_total;
        localparam int swap_line    = 100;
        localparam int reset_cycles = 16;
        localparam int settle       = 8;
        localparam int max_vectors  = 16;

        logic pclk = 1'b0;
        logic rst;
        coord_t vcount_in;
        coord_t hcount_in;
        logic vsync_in;
        logic hsync_in;
        logic vblnk_in;
        logic hblnk_in;
        rgb_t rgb_in;
        bcd_word_t [num_words-1:0] bcd_words;
        logic vsync_out;
        logic hsync_out;
        rgb_t rgb_out;

        integer seed = 47;
        string digit_sets [10] = '{"abcdef", "bc", "abdeg", "abcdg", "bcfg",
                                   "acdfg", "acdefg", "abc", "abcdefg", "abcdfg"};

        string     vec_names  [max_vectors];
        bcd_word_t vec_words  [max_vectors][num_words];
        int        vec_swap   [max_vectors];
        int        vec_frames [max_vectors];
        int        num_vectors  = 0;
        int        total_frames = 0;

        bcd_word_t cur_words   [num_words];   // Words on the DUT inputs
        bcd_word_t shown_words [num_words];   // Words captured at the last vblank
        string     cur_name = "reset";
        rgb_t      exp_rgb_q [$];
        logic      exp_vs_q [$];
        logic      exp_hs_q [$];
        int        exp_pos_q [$];
        bit        checking = 1'b0;
        int        num_checks = 0;
        int        cycle_count = 0;
        int        cycle_limit = 0;

        osd_top #(
                .xpos      (xpos),
                .ypos      (ypos),
                .num_words (num_words),
                .text_rgb  (text_rgb)
        ) i_osd_top (
                .pclk      (pclk),
                .rst       (rst),
                .vcount_in (vcount_in),
                .hcount_in (hcount_in),
                .vsync_in  (vsync_in),
                .hsync_in  (hsync_in),
                .vblnk_in  (vblnk_in),
                .hblnk_in  (hblnk_in),
                .rgb_in    (rgb_in),
                .bcd_words (bcd_words),
                .vsync_out (vsync_out),
                .hsync_out (hsync_out),
                .rgb_out   (rgb_out)
        );

        always #20 pclk = ~pclk;

        task automatic abort_run(input string why);
                $display("%0s", why);
                $display("RESULT: FAIL");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_rgb(input string what, input rgb_t exp, input rgb_t act);
                num_checks++;
                if (act !== exp) begin
                        $display("ERROR %0s: %0s expected %h actual %h", cur_name, what, exp, act);
                        abort_run("rgb_out differs from the reference model");
                end
        endtask

        task automatic check_sync(input string what, input logic exp, input logic act);
                num_checks++;
                if (act !== exp) begin
                        $display("ERROR %0s: %0s expected %b actual %b", cur_name, what, exp, act);
                        abort_run("sync output differs from the delayed input");
                end
        endtask

        function automatic bit in_rect(input int r, input int c, input int r0, input int r1,
                                       input int c0, input int c1);
                return r >= r0 && r <= r1 && c >= c0 && c <= c1;
        endfunction

        function automatic bit seg_pixel(input int d, input int r, input int c);
                string segs;
                bit    lit;
                segs = digit_sets[d];
                lit = 1'b0;
                for (int i = 0; i < segs.len(); i++) begin
                        case (segs[i])
                                "a": lit |= in_rect(r, c, 1, 2, 1, 6);
                                "b": lit |= in_rect(r, c, 2, 7, 6, 7);
                                "c": lit |= in_rect(r, c, 8, 13, 6, 7);
                                "d": lit |= in_rect(r, c, 13, 14, 1, 6);
                                "e": lit |= in_rect(r, c, 8, 13, 0, 1);
                                "f": lit |= in_rect(r, c, 2, 7, 0, 1);
                                "g": lit |= in_rect(r, c, 7, 8, 1, 6);
                                default: lit |= 1'b0;
                        endcase
                end
                return lit;
        endfunction

        function automatic rgb_t expected_rgb(input int h, input int v, input rgb_t pic);
                int col;
                int line;
                logic [3:0] nib;
                if (h < xpos || h >= xpos + 4 * 8 || v < ypos || v >= ypos + num_words * 16)
                        return pic;
                col  = (h - xpos) / 8;
                line = (v - ypos) / 16;
                nib  = shown_words[line][(3 - col) * 4 +: 4];   // Column 0 is the top digit
                if (nib <= 4'd9 && seg_pixel(nib, (v - ypos) % 16, (h - xpos) % 8))
                        return text_rgb;
                return pic;
        endfunction

        // Drives one pixel and queues what the outputs show four cycles later
        task automatic drive_pixel(input int h, input int v);
                rgb_t pic;
                logic vs;
                logic hs;
                pic = rgb_t'($random(seed));
                vs  = (v >= 226 && v <= 227);
                hs  = (h >= 56 && h <= 59);
                if (v == v_blank && h == 0)
                        shown_words = cur_words;
                vcount_in <= coord_t'(v);
                hcount_in <= coord_t'(h);
                vsync_in  <= vs;
                hsync_in  <= hs;
                vblnk_in  <= (v >= v_blank);
                hblnk_in  <= (h >= h_blank);
                rgb_in    <= pic;
                exp_rgb_q.push_back(expected_rgb(h, v, pic));
                exp_vs_q.push_back(vs);
                exp_hs_q.push_back(hs);
                exp_pos_q.push_back(v * 4096 + h);
        endtask

        task automatic set_words(input int n, input bit rotate);
                bcd_word_t w;
                for (int i = 0; i < num_words; i++) begin
                        w = vec_words[n][i];
                        if (rotate)
                                w = {w[11:0], w[15:12]};   // Each digit moves one place left
                        cur_words[i] = w;
                        bcd_words[i] <= w;
                end
        endtask

        task automatic load_vectors();
                int    fd;
                int    got;
                string line;
                fd = $fopen("sim/osd_vectors.txt", "r");
                if (fd == 0) begin
                        abort_run("cannot open the vector file sim/osd_vectors.txt");
                end else begin
                        while (!$feof(fd) && num_vectors < max_vectors) begin
                                got = $fgets(line, fd);
                                if (got > 0 && line.len() > 1 && line[0] != "#") begin
                                        got = $sscanf(line,
                                                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %d %d",
                                                vec_names[num_vectors],
                                                vec_words[num_vectors][0], vec_words[num_vectors][1],
                                                vec_words[num_vectors][2], vec_words[num_vectors][3],
                                                vec_words[num_vectors][4], vec_words[num_vectors][5],
                                                vec_words[num_vectors][6], vec_words[num_vectors][7],
                                                vec_words[num_vectors][8], vec_words[num_vectors][9],
                                                vec_words[num_vectors][10], vec_words[num_vectors][11],
                                                vec_words[num_vectors][12],
                                                vec_swap[num_vectors], vec_frames[num_vectors]);
                                        if (got != 16) begin
                                                abort_run({"malformed line in the vector file: ", line});
                                        end else begin
                                                total_frames += vec_frames[num_vectors];
                                                num_vectors++;
                                        end
                                end
                        end
                        $fclose(fd);
                end
        endtask

        always @(posedge pclk) begin
                cycle_count++;
                if (cycle_limit != 0 && cycle_count > cycle_limit)
                        abort_run($sformatf("timeout after %0d cycles", cycle_count));
        end

        always @(negedge pclk) begin
                rgb_t  e_rgb;
                logic  e_vs;
                logic  e_hs;
                int    pos;
                string where;
                if (exp_rgb_q.size() > 4) begin
                        e_rgb = exp_rgb_q.pop_front();
                        e_vs  = exp_vs_q.pop_front();
                        e_hs  = exp_hs_q.pop_front();
                        pos   = exp_pos_q.pop_front();
                        if (checking) begin
                                where = $sformatf("x %0d y %0d", pos % 4096, pos / 4096);
                                check_sync({"vsync_out at ", where}, e_vs, vsync_out);
                                check_sync({"hsync_out at ", where}, e_hs, hsync_out);
                                check_rgb({"rgb_out at ", where}, e_rgb, rgb_out);
                        end
                end
        end

        initial begin
                rst       <= 1'b1;
                vcount_in <= '0;
                hcount_in <= '0;
                vsync_in  <= 1'b0;
                hsync_in  <= 1'b0;
                vblnk_in  <= 1'b0;
                hblnk_in  <= 1'b0;
                rgb_in    <= '0;
                bcd_words <= '1;
                cur_words   = '{default: 16'hffff};   // Blank until the first capture
                shown_words = '{default: 16'hffff};
                load_vectors();
                cycle_limit = total_frames * frame_len + reset_cycles + settle + 1000;

                for (int i = 0; i < reset_cycles + settle; i++) begin
                        @(posedge pclk);
                        if (i == reset_cycles - 1)
                                rst <= 1'b0;
                        drive_pixel(0, 0);
                end
                checking = 1'b1;

                for (int n = 0; n < num_vectors; n++) begin
                        cur_name = vec_names[n];
                        for (int f = 0; f < vec_frames[n]; f++) begin
                                for (int v = 0; v < v_total; v++) begin
                                        for (int h = 0; h < h_total; h++) begin
                                                @(posedge pclk);
                                                if (f == 0 && v == 0 && h == 0)
                                                        set_words(n, 1'b0);
                                                if (vec_swap[n] != 0 && f == vec_frames[n] - 1 &&
                                                    v == swap_line && h == 0)
                                                        set_words(n, 1'b1);
                                                drive_pixel(h, v);
                                        end
                                end
                        end
                end

                // Flush the pipeline so the last pixels are compared
                repeat (6) begin
                        @(posedge pclk);
                        drive_pixel(0, 0);
                end
                @(posedge pclk);   // Every compare of the last falling edge is done by now
                if (num_vectors > 0 && num_checks > 0) begin
                        $display("RESULT: PASS");
                        $finish;
                end else begin
                        abort_run("no vectors were loaded or no output was compared");
                end
        end

endmodule

`default_nettype wire

//--- files.f
hdl/osd_pkg.sv
hdl/video_if.sv
hdl/snapshot_fsm.sv
hdl/word_counter.sv
hdl/text_buffer.sv
hdl/glyph_gen.sv
hdl/osd_draw.sv
hdl/osd_top.sv
sim/osd_tb.sv

//--- sim/osd_vectors.txt
# name, thirteen BCD words in hex (word 0 first), mid-frame swap flag, frame count
# With the swap flag set the words are rotated by one digit on line 100 of the last frame
digits_a    0123 4567 8901 2345 6789 9876 5432 1098 7654 3210 1111 8888 0000 0 2
nibbles_hi  abcd efab cdef a0b1 c2d3 e4f5 9a8b ffff fafa 0f0f 7c7c 1e1e dddd 0 2
swap_mid    1234 2345 3456 4567 5678 6789 7890 8901 9012 0123 4444 5555 6666 1 2
after_swap  9999 8888 7777 6666 5555 4444 3333 2222 1111 0000 1a2b 3c4d 5e6f 0 1
all_eights  8888 8888 8888 8888 8888 8888 8888 8888 8888 8888 8888 8888 8888 1 1
zeros       0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 1
mixed_a     0a19 b2c3 4d5e 6f70 0909 9090 a5a5 5a5a 1001 2002 3003 4004 5005 0 2
ones_sevens 1717 7171 1177 7711 1b1b 7f7f 0170 0710 1007 7001 1234 4321 0007 1 2
final_mix   2468 1357 0246 9753 8642 3579 ffff 0000 a0a0 0a0a 9999 8080 0808 0 1
